// File: src.f
+incdir+src
src/stream_pkg.sv
src/skid_buf.sv
src/csum_append.sv
src/csum_pipe_top.sv
sim/csum_pipe_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the checksum pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --timescale 1ns/10ps \
  -f src.f \
  --top-module csum_pipe_tb \
  -o csum_pipe_sim

./obj_dir/csum_pipe_sim > "$LOG" 2>&1 || true
cat "$LOG"

# The testbench prints its pass line only when every check held
if grep -q "All checks passed" "$LOG"; then
  echo "Simulation PASS"
  exit 0
else
  echo "Simulation FAIL"
  exit 1
fi

// File: sim/csum_pipe_tb.sv
`timescale 1ns/10ps

// Directed testbench for the checksum pipeline
// Expected beats come from a model queue built from the bytes sent.
module csum_pipe_tb;
  import stream_pkg::*;

  localparam int TIMEOUT = 200;  // Cycles allowed for one wait

  logic  clk;
  logic  rst_n;
  logic  i_valid;
  logic  o_ready;
  beat_t i_beat;
  logic  o_valid;
  logic  i_ready;
  beat_t o_beat;

  beat_t  model_q[$];  // Expected output beats in order
  data_t  model_sum;   // Sum of bytes in the packet being sent
  data_t  out_sum;     // Sum of output bytes in the current packet
  integer seed;
  int     mismatches;
  int     failures;

  csum_pipe_top csum_pipe_top_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_valid(i_valid),
    .o_ready(o_ready),
    .i_beat (i_beat),
    .o_valid(o_valid),
    .i_ready(i_ready),
    .o_beat (o_beat)
  );

  always #2 clk = ~clk;

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      mismatches++;
      $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      mismatches++;
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_beat(input string name, input beat_t exp, input beat_t act);
    if (act !== exp) begin
      mismatches++;
      $display("mismatch at %0t: %s expected data=%h last=%b actual data=%h last=%b",
               $time, name, exp.data, exp.last, act.data, act.last);
    end
  endtask

  task automatic report_failure(input string what);
    failures++;
    $display("failure at %0t: %s", $time, what);
  endtask

  // Reference model
  task automatic expect_byte(input data_t d);
    beat_t b;
    b.data = d;
    b.last = 1'b0;  // Last only marks the checksum byte
    model_q.push_back(b);
    model_sum = model_sum + d;
  endtask

  task automatic expect_checksum();
    beat_t b;
    b.data = '0 - model_sum;  // Negated modulo-256 sum
    b.last = 1'b1;
    model_q.push_back(b);
    model_sum = '0;
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_beat(input data_t d, input logic l);
    int waited;
    waited      = 0;
    i_valid     = 1'b1;
    i_beat.data = d;
    i_beat.last = l;
    while (!o_ready && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!o_ready) begin
      report_failure("o_ready stayed low while a byte was offered");
    end
    @(negedge clk);
    i_valid = 1'b0;
  endtask

  task automatic send_packet(input data_t bytes[$]);
    int i;
    for (i = 0; i < bytes.size(); i++) begin
      expect_byte(bytes[i]);
    end
    expect_checksum();
    for (i = 0; i < bytes.size(); i++) begin
      send_beat(bytes[i], logic'(i == bytes.size() - 1));
    end
  endtask

  task automatic send_random_packet(input int len);
    data_t       bytes[$];
    logic [31:0] r;
    int          i;
    for (i = 0; i < len; i++) begin
      r = $random(seed);
      bytes.push_back(data_t'(r));
    end
    send_packet(bytes);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (model_q.size() != 0 && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (model_q.size() != 0) begin
      report_failure("output stream stopped with beats still expected");
    end
  endtask

  task automatic apply_reset();
    rst_n   = 1'b0;
    i_valid = 1'b0;
    repeat (2) @(negedge clk);
    model_q.delete();  // Beats in flight are dropped by reset
    model_sum = '0;
    rst_n     = 1'b1;
  endtask

  task automatic test_after_reset();
    check_bit("o_valid", 1'b0, o_valid);
    check_bit("o_ready", 1'b1, o_ready);
  endtask

  task automatic test_single_packet();
    data_t pkt[4];
    beat_t exp;
    int    i;
    pkt     = '{8'h12, 8'h34, 8'h56, 8'h78};
    i_ready = 1'b1;
    for (i = 0; i < 4; i++) begin
      expect_byte(pkt[i]);
    end
    expect_checksum();
    send_beat(pkt[0], 1'b0);
    // First byte visible one cycle after acceptance
    check_bit("o_valid", 1'b1, o_valid);
    exp.data = pkt[0];
    exp.last = 1'b0;
    check_beat("o_beat", exp, o_beat);
    for (i = 1; i < 4; i++) begin
      send_beat(pkt[i], logic'(i == 3));
    end
    wait_drain();
  endtask

  task automatic test_back_to_back();
    data_t p[$];
    i_ready = 1'b1;
    p = '{8'hA5};
    send_packet(p);
    p = '{8'h01, 8'hFF, 8'h80};
    send_packet(p);
    p = '{8'h00};
    send_packet(p);
    p = '{8'h7F, 8'h81};
    send_packet(p);
    p = '{8'hC3};
    send_packet(p);
    wait_drain();
  endtask

  task automatic test_backpressure();
    logic [31:0] r;
    data_t       d;
    int          n;
    i_ready = 1'b0;
    n       = 0;
    while (o_ready && n < 16) begin
      r = $random(seed);
      d = data_t'(r);
      expect_byte(d);
      i_valid     = 1'b1;
      i_beat.data = d;
      i_beat.last = 1'b0;
      @(negedge clk);
      n++;
    end
    i_valid = 1'b0;
    if (o_ready) begin
      report_failure("o_ready stayed high with the output stalled");
    end
    check_bit("o_valid", 1'b1, o_valid);
    i_ready = 1'b1;
    r = $random(seed);
    d = data_t'(r);
    expect_byte(d);
    expect_checksum();
    send_beat(d, 1'b1);  // Close the packet
    wait_drain();
    check_bit("o_ready", 1'b1, o_ready);
    check_bit("o_valid", 1'b0, o_valid);
  endtask

  task automatic test_random_traffic();
    logic [31:0] r_send;
    logic [31:0] r_ready;
    logic        done;
    int          pkt;
    int          waited;
    done = 1'b0;
    fork
      begin
        for (pkt = 0; pkt < 12; pkt++) begin
          r_send = $random(seed);
          send_random_packet(int'(r_send[2:0]) + 1);  // 1 to 8 bytes
        end
        done = 1'b1;
      end
      begin
        waited = 0;
        while (!done && waited < 20 * TIMEOUT) begin
          @(posedge clk);
          r_ready = $random(seed);
          @(negedge clk);
          i_ready = r_ready[0];
          waited++;
        end
        i_ready = 1'b1;
      end
    join
    i_ready = 1'b1;
    wait_drain();
  endtask

  task automatic test_reset_mid_packet();
    data_t p[$];
    i_ready = 1'b0;
    send_beat(8'h3C, 1'b0);
    send_beat(8'h5A, 1'b0);
    send_beat(8'h96, 1'b0);
    check_bit("o_valid", 1'b1, o_valid);  // Beats sit in the buffers
    apply_reset();
    check_bit("o_valid", 1'b0, o_valid);
    check_bit("o_ready", 1'b1, o_ready);
    i_ready = 1'b1;
    p = '{8'h10, 8'h20, 8'h30};
    send_packet(p);
    wait_drain();
  endtask

  // Output monitor, pops the model on every output transfer
  initial begin : output_monitor
    beat_t exp;
    out_sum = '0;
    forever begin
      @(posedge clk);
      if (!rst_n) begin
        out_sum = '0;
      end else if (o_valid && i_ready) begin
        if (model_q.size() == 0) begin
          report_failure("output beat appeared with no beat expected");
        end else begin
          exp = model_q.pop_front();
          check_beat("o_beat", exp, o_beat);
        end
        out_sum = out_sum + o_beat.data;
        if (o_beat.last) begin
          check_data("packet sum", '0, out_sum);
          out_sum = '0;
        end
      end
    end
  end

  initial begin
    seed       = 63933;
    mismatches = 0;
    failures   = 0;
    model_sum  = '0;
    clk        = 1'b0;
    rst_n      = 1'b0;
    i_valid    = 1'b0;
    i_beat     = '0;
    i_ready    = 1'b1;

    apply_reset();
    test_after_reset();
    test_single_packet();
    test_back_to_back();
    test_backpressure();
    test_random_traffic();
    test_reset_mid_packet();

    $display("Mismatches: %0d, other failures: %0d", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: src/csum_pipe_top.sv
`timescale 1ns/10ps

// Byte stream checksum pipeline
// Input skid buffer, checksum stage, then a skid buffer with a
// registered output. Each packet of L bytes leaves as L+1 beats.
module csum_pipe_top (
  input  logic              clk,
  input  logic              rst_n,

  input  logic              i_valid,
  output logic              o_ready,
  input  stream_pkg::beat_t i_beat,

  output logic              o_valid,
  input  logic              i_ready,
  output stream_pkg::beat_t o_beat
);
  import stream_pkg::*;

  // in_buf to csum
  logic  in_valid;
  logic  in_ready;
  beat_t in_beat;

  // csum to out_buf
  logic  cs_valid;
  logic  cs_ready;
  beat_t cs_beat;

  // Registered ready toward the outside, no output register
  skid_buf #(
    .OPT_OUTREG(1'b0)
  ) in_buf (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_valid(i_valid),
    .o_ready(o_ready),
    .i_data (i_beat),
    .o_valid(in_valid),
    .i_ready(in_ready),
    .o_data (in_beat)
  );

  csum_append csum (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_valid(in_valid),
    .o_ready(in_ready),
    .i_beat (in_beat),
    .o_valid(cs_valid),
    .i_ready(cs_ready),
    .o_beat (cs_beat)
  );

  // Registered output, one cycle through the pipe
  skid_buf #(
    .OPT_OUTREG(1'b1)
  ) out_buf (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_valid(cs_valid),
    .o_ready(cs_ready),
    .i_data (cs_beat),
    .o_valid(o_valid),
    .i_ready(i_ready),
    .o_data (o_beat)
  );

endmodule

// File: src/csum_append.sv
`timescale 1ns/10ps

// Checksum stage
// Forwards packet bytes and appends one byte after each packet so that
// every output packet sums to zero modulo 256.
module csum_append (
  input  logic              clk,
  input  logic              rst_n,

  input  logic              i_valid,
  output logic              o_ready,
  input  stream_pkg::beat_t i_beat,

  output logic              o_valid,
  input  logic              i_ready,
  output stream_pkg::beat_t o_beat
);
  import stream_pkg::*;

  csum_state_t state;
  csum_state_t next_state;

  data_t sum;       // Running sum of accepted bytes
  data_t next_sum;
  data_t neg_sum;   // Two's complement of sum

  logic in_xfer;
  logic out_xfer;

  assign neg_sum  = data_t'(~sum + 1'b1);
  assign in_xfer  = i_valid && o_ready;
  assign out_xfer = o_valid && i_ready;

  // Handshake and output beat
  always_comb begin
    o_ready     = 1'b0;
    o_valid     = 1'b0;
    o_beat      = i_beat;
    o_beat.last = 1'b0;

    case (state)
      PASS: begin
        o_ready     = i_ready;  // No storage here, follow downstream
        o_valid     = i_valid;
        o_beat.data = i_beat.data;
        o_beat.last = 1'b0;     // Last moves to the checksum byte
      end

      EMIT: begin
        o_ready     = 1'b0;     // Input stalls for one beat
        o_valid     = 1'b1;
        o_beat.data = neg_sum;
        o_beat.last = 1'b1;
      end

      default: begin
        o_ready = 1'b0;
        o_valid = 1'b0;
      end
    endcase
  end

  // Next state and sum
  always_comb begin
    next_state = state;
    next_sum   = sum;

    case (state)
      PASS: begin
        if (in_xfer) begin
          next_sum = sum + i_beat.data;  // Wraps modulo 256
          if (i_beat.last) begin
            next_state = EMIT;
          end
        end
      end

      EMIT: begin
        if (out_xfer) begin
          next_state = PASS;
          next_sum   = '0;  // Fresh packet
        end
      end

      default: begin
        next_state = PASS;
        next_sum   = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= PASS;
      sum   <= '0;
    end else begin
      state <= next_state;
      sum   <= next_sum;
    end
  end

endmodule

// File: src/skid_buf.sv
`timescale 1ns/10ps

`include "stream_consts.svh"

// Valid/ready skid buffer
// o_ready comes straight from a flop, so the upstream ready path is cut.
// A beat that arrives while the downstream stalls lands in the skid register.
module skid_buf #(
  parameter bit OPT_OUTREG = `STREAM_OPT_OUTREG
) (
  input  logic              clk,
  input  logic              rst_n,

  input  logic              i_valid,
  output logic              o_ready,
  input  stream_pkg::beat_t i_data,

  output logic              o_valid,
  input  logic              i_ready,
  output stream_pkg::beat_t o_data
);
  import stream_pkg::*;

  logic  skid_valid;
  beat_t skid_data;

  logic  in_xfer;  // Upstream transfer this cycle
  logic  hold;     // Stage behind the skid register cannot take a beat

  assign in_xfer = i_valid && o_ready;

  // Ready is high exactly when the skid register is empty
  assign o_ready = !skid_valid;

  // Skid register control
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      skid_valid <= 1'b0;
    end else if (in_xfer && hold) begin
      skid_valid <= 1'b1;  // Catch the beat in flight
    end else if (!hold) begin
      skid_valid <= 1'b0;  // Drained downstream
    end
  end

  always_ff @(posedge clk) begin
    if (in_xfer && hold) begin
      skid_data <= i_data;
    end
  end

  generate
    if (OPT_OUTREG) begin : g_outreg
      logic  out_valid;
      beat_t out_data;

      // Output register is full and not being taken
      assign hold = out_valid && !i_ready;

      always_ff @(posedge clk) begin
        if (!rst_n) begin
          out_valid <= 1'b0;
        end else if (!hold) begin
          out_valid <= skid_valid || in_xfer;
        end
      end

      // Skid beat is older, so it goes first
      always_ff @(posedge clk) begin
        if (!hold) begin
          out_data <= skid_valid ? skid_data : i_data;
        end
      end

      assign o_valid = out_valid;
      assign o_data  = out_data;
    end else begin : g_comb
      assign hold = !i_ready;

      // Input passes through while the skid register is empty
      assign o_valid = skid_valid || i_valid;
      assign o_data  = skid_valid ? skid_data : i_data;
    end
  endgenerate

endmodule

// File: src/stream_pkg.sv
`include "stream_consts.svh"

package stream_pkg;

  // One byte of payload or one modulo-256 running sum
  typedef logic [`STREAM_DATA_W-1:0] data_t;

  // One transfer on a valid/ready link
  typedef struct packed {
    data_t data;
    logic  last;  // Final beat of a packet
  } beat_t;

  // Checksum stage states
  typedef enum logic {
    PASS, // Forwarding packet bytes
    EMIT  // Offering the checksum byte
  } csum_state_t;

endpackage

// File: src/stream_consts.svh
`ifndef STREAM_CONSTS_SVH
`define STREAM_CONSTS_SVH

// Width of one stream byte, also the width of the running checksum
`define STREAM_DATA_W 8

// Default for the skid buffer output register option
// 0 gives a combinational path from input to output when the skid is empty
// 1 puts a register on o_valid and o_data
`define STREAM_OPT_OUTREG 1'b0

`endif
